/* dv/mcm_tb_model.svh */
`ifndef MCM_TB_MODEL_SVH
`define MCM_TB_MODEL_SVH

// Row k, column n of each constant matrix
localparam int DCT4_REF [4][4] = '{
  '{64,  64,  64,  64},
  '{83,  36, -36, -83},
  '{64, -64, -64,  64},
  '{36, -83,  83, -36}
};

localparam int DST4_REF [4][4] = '{
  '{29,  55,  74,  84},
  '{74,  74,   0, -74},
  '{84, -29, -74,  55},
  '{55, -84,  74, -29}
};

localparam int ODD8_REF [4][4] = '{
  '{89,  75,  50,  18},
  '{75, -18, -89, -50},
  '{50, -89,  18,  75},
  '{18, -50,  75, -89}
};

int error_count = 0;
logic [31:0] lcg_state = 32'hf947b88d;

function automatic int coef_of(input mcm_pkg::coef_set_e cset, input int k, input int n);
  case (cset)
    mcm_pkg::COEF_DST4: return DST4_REF[k][n];
    mcm_pkg::COEF_ODD8: return ODD8_REF[k][n];
    default: return DCT4_REF[k][n];
  endcase
endfunction

// Forward y[k] = sum M[k][n] x[n], inverse y[n] = sum M[k][n] x[k]
function automatic mcm_pkg::quad_result_t engine_ref(input mcm_pkg::coef_set_e cset,
                                                     input logic inv,
                                                     input mcm_pkg::quad_sample_t x);
  mcm_pkg::quad_result_t y;
  longint acc;
  for (int i = 0; i < 4; i++) begin
    acc = 0;
    for (int j = 0; j < 4; j++) begin
      if (inv) begin
        acc = acc + longint'(coef_of(cset, j, i)) * longint'(x[j]);
      end else begin
        acc = acc + longint'(coef_of(cset, i, j)) * longint'(x[j]);
      end
    end
    y[i] = mcm_pkg::result_t'(acc);
  end
  return y;
endfunction

function automatic mcm_pkg::result_vec_t expected_vec(input mcm_pkg::sample_vec_t s,
                                                      input mcm_pkg::tr_size_e size,
                                                      input logic dst,
                                                      input logic inv);
  mcm_pkg::result_vec_t y;
  mcm_pkg::quad_sample_t lo;
  mcm_pkg::quad_sample_t hi;
  mcm_pkg::quad_result_t lo_y;
  mcm_pkg::quad_result_t hi_y;
  y = '0;
  for (int g = 0; g < `MCM_LANES / `MCM_GROUP_LANES; g++) begin
    for (int l = 0; l < 4; l++) begin
      lo[l] = s[g * `MCM_GROUP_LANES + l];
      hi[l] = s[g * `MCM_GROUP_LANES + 4 + l];
    end
    if (size == mcm_pkg::TR_SIZE_8) begin
      lo_y = engine_ref(mcm_pkg::COEF_DCT4, inv, lo);
      hi_y = engine_ref(mcm_pkg::COEF_ODD8, inv, hi);
    end else if (dst) begin
      lo_y = engine_ref(mcm_pkg::COEF_DST4, inv, lo);
      hi_y = '0;
    end else begin
      lo_y = engine_ref(mcm_pkg::COEF_DCT4, inv, lo);
      hi_y = '0;
    end
    for (int l = 0; l < 4; l++) begin
      y[g * `MCM_GROUP_LANES + l] = lo_y[l];
      y[g * `MCM_GROUP_LANES + 4 + l] = hi_y[l];
    end
  end
  return y;
endfunction

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Upper LCG bits, the low ones have short periods
function automatic mcm_pkg::sample_vec_t random_vec();
  mcm_pkg::sample_vec_t v;
  logic [31:0] r;
  for (int l = 0; l < `MCM_LANES; l++) begin
    r = lcg_next();
    v[l] = mcm_pkg::sample_t'(r[31:13]);
  end
  return v;
endfunction

task automatic check_results(input mcm_pkg::result_vec_t want, input mcm_pkg::result_vec_t got);
  for (int l = 0; l < `MCM_LANES; l++) begin
    if (got[l] !== want[l]) begin
      $display("mismatch at %0t ns: o_results[%0d] expected %0d, got %0d",
               $time, l, want[l], got[l]);
      error_count++;
    end
  end
endtask

task automatic check_valid(input logic want, input logic got);
  if (got !== want) begin
    $display("mismatch at %0t ns: o_valid expected %b, got %b", $time, want, got);
    error_count++;
  end
endtask

`endif

/* dv/mcm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcm_cfg.svh"

module mcm_tb;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 16;
  localparam int SETTLE_CYCLES = 4;
  localparam int DRAIN_CYCLES = 8;
  localparam int SIZE4_ITEMS = 2 * (`MCM_LANES + 2);
  localparam int SIZE8_ITEMS = 64;
  localparam int MIX_CYCLES = 96;
  localparam int TOTAL_CYCLES = RESET_CYCLES + SETTLE_CYCLES
                              + 2 * (SIZE4_ITEMS + DRAIN_CYCLES)
                              + SIZE8_ITEMS + DRAIN_CYCLES
                              + MIX_CYCLES + DRAIN_CYCLES;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 i_valid;
  logic                 i_inverse;
  mcm_pkg::tr_size_e    i_size;
  logic                 i_dst_sel;
  mcm_pkg::sample_vec_t i_samples;
  logic                 o_valid;
  mcm_pkg::result_vec_t o_results;

  // Expected results in input order
  mcm_pkg::result_vec_t       exp_q [$];
  logic [`MCM_PIPE_DEPTH-1:0] valid_hist;
  int                         tests_run;
  int                         tests_failed;

  `include "mcm_tb_model.svh"

  mcm_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .i_valid   (i_valid),
    .i_inverse (i_inverse),
    .i_size    (i_size),
    .i_dst_sel (i_dst_sel),
    .i_samples (i_samples),
    .o_valid   (o_valid),
    .o_results (o_results)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Strobe sampled at a falling edge shows on o_valid two falling edges later
  always @(negedge clk) begin : out_monitor
    logic want_v;
    mcm_pkg::result_vec_t want_r;
    want_v = valid_hist[`MCM_PIPE_DEPTH-1];
    check_valid(want_v, o_valid);
    if (want_v) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t ns: output expected but no result is queued", $time);
        error_count++;
      end else begin
        want_r = exp_q.pop_front();
        check_results(want_r, o_results);
      end
    end else begin
      check_results('0, o_results);
    end
    valid_hist = {valid_hist[`MCM_PIPE_DEPTH-2:0], i_valid};
  end

  task automatic send_item(input mcm_pkg::sample_vec_t samples, input mcm_pkg::tr_size_e size,
                           input logic dst, input logic inv);
    @(posedge clk);
    #2;
    i_valid   = 1'b1;
    i_samples = samples;
    i_size    = size;
    i_dst_sel = dst;
    i_inverse = inv;
    exp_q.push_back(expected_vec(samples, size, dst, inv));
  endtask

  // Data and mode toggle while the strobe is low
  task automatic send_idle(input mcm_pkg::sample_vec_t samples, input mcm_pkg::tr_size_e size,
                           input logic dst, input logic inv);
    @(posedge clk);
    #2;
    i_valid   = 1'b0;
    i_samples = samples;
    i_size    = size;
    i_dst_sel = dst;
    i_inverse = inv;
  endtask

  task automatic drain_pipeline();
    @(posedge clk);
    #2;
    i_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests_run++;
    if (error_count == start_errors) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, error_count - start_errors);
    end
  endtask

  task automatic reset_behavior();
    int start_errors;
    start_errors = error_count;
    rst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b1;
    repeat (SETTLE_CYCLES) @(posedge clk);
    report_test("reset", start_errors);
  endtask

  task automatic size4_directed(input logic dst, input string name);
    mcm_pkg::sample_vec_t vec;
    int start_errors;
    start_errors = error_count;
    for (int dir = 0; dir < 2; dir++) begin
      // Unit impulse walks across all 32 lanes
      for (int lane = 0; lane < `MCM_LANES; lane++) begin
        vec = '0;
        vec[lane] = mcm_pkg::sample_t'(1);
        send_item(vec, mcm_pkg::TR_SIZE_4, dst, dir[0]);
      end
      for (int l = 0; l < `MCM_LANES; l++) begin
        vec[l] = {1'b0, {(`MCM_SAMPLE_W - 1){1'b1}}};
      end
      send_item(vec, mcm_pkg::TR_SIZE_4, dst, dir[0]);
      for (int l = 0; l < `MCM_LANES; l++) begin
        vec[l] = {1'b1, {(`MCM_SAMPLE_W - 1){1'b0}}};
      end
      send_item(vec, mcm_pkg::TR_SIZE_4, dst, dir[0]);
    end
    drain_pipeline();
    report_test(name, start_errors);
  endtask

  task automatic size8_random();
    logic [31:0] r;
    int start_errors;
    start_errors = error_count;
    for (int i = 0; i < SIZE8_ITEMS; i++) begin
      r = lcg_next();
      send_item(random_vec(), mcm_pkg::TR_SIZE_8, r[31], r[30]);
    end
    drain_pipeline();
    report_test("size8_random", start_errors);
  endtask

  task automatic mode_mix();
    logic [31:0] r;
    mcm_pkg::tr_size_e size;
    int start_errors;
    start_errors = error_count;
    for (int i = 0; i < MIX_CYCLES; i++) begin
      r = lcg_next();
      size = r[27] ? mcm_pkg::TR_SIZE_8 : mcm_pkg::TR_SIZE_4;
      // About one cycle in four is idle
      if (r[31:30] == 2'b00) begin
        send_idle(random_vec(), size, r[26], r[25]);
      end else begin
        send_item(random_vec(), size, r[26], r[25]);
      end
    end
    drain_pipeline();
    report_test("mode_mix", start_errors);
  endtask

  initial begin
    rst          = 1'b0;
    i_valid      = 1'b0;
    i_inverse    = 1'b0;
    i_size       = mcm_pkg::TR_SIZE_4;
    i_dst_sel    = 1'b0;
    i_samples    = '0;
    valid_hist   = '0;
    tests_run    = 0;
    tests_failed = 0;
    reset_behavior();
    size4_directed(1'b0, "size4_cosine");
    size4_directed(1'b1, "size4_sine");
    size8_random();
    mode_mix();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(4 * TOTAL_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles before all tests completed", 4 * TOTAL_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/mcm_cfg.svh */
`ifndef MCM_CFG_SVH
`define MCM_CFG_SVH

// Lanes presented per clock
`define MCM_LANES 32

// Lanes handled by one engine group
`define MCM_GROUP_LANES 8

// Residual sample width
`define MCM_SAMPLE_W 19

// Transform coefficient width
`define MCM_COEF_W 8

// Width of one multiply-accumulate result
`define MCM_RESULT_W 28

// Clock edges from input strobe to output valid
`define MCM_PIPE_DEPTH 2

`endif

/* rtl/mcm_coef_matrix.sv */
`timescale 1ns/1ps
`default_nettype none

module mcm_coef_matrix #(
  parameter mcm_pkg::coef_set_e COEF_SET = mcm_pkg::COEF_DCT4
) (
  input  wire                   i_inverse,
  input  wire mcm_pkg::quad_sample_t i_x,
  output mcm_pkg::quad_result_t o_y
);

  // Row k, column n
  typedef mcm_pkg::coef_t [0:3][0:3] coef_mat_t;

  localparam coef_mat_t DCT4_MAT = '{
    '{8'sd64,  8'sd64,  8'sd64,  8'sd64},
    '{8'sd83,  8'sd36, -8'sd36, -8'sd83},
    '{8'sd64, -8'sd64, -8'sd64,  8'sd64},
    '{8'sd36, -8'sd83,  8'sd83, -8'sd36}
  };

  localparam coef_mat_t DST4_MAT = '{
    '{8'sd29,  8'sd55,  8'sd74,  8'sd84},
    '{8'sd74,  8'sd74,  8'sd0,  -8'sd74},
    '{8'sd84, -8'sd29, -8'sd74,  8'sd55},
    '{8'sd55, -8'sd84,  8'sd74, -8'sd29}
  };

  // Odd rows 1, 3, 5, 7 of the 8-point cosine
  localparam coef_mat_t ODD8_MAT = '{
    '{8'sd89,  8'sd75,  8'sd50,  8'sd18},
    '{8'sd75, -8'sd18, -8'sd89, -8'sd50},
    '{8'sd50, -8'sd89,  8'sd18,  8'sd75},
    '{8'sd18, -8'sd50,  8'sd75, -8'sd89}
  };

  localparam coef_mat_t MAT = (COEF_SET == mcm_pkg::COEF_DST4) ? DST4_MAT :
                              (COEF_SET == mcm_pkg::COEF_ODD8) ? ODD8_MAT :
                                                                 DCT4_MAT;

  // Forward reads M by rows, inverse by columns (transpose)
  always_comb begin
    mcm_pkg::result_t acc;
    mcm_pkg::coef_t   coef;
    for (int r = 0; r < 4; r++) begin
      acc = '0;
      for (int c = 0; c < 4; c++) begin
        if (i_inverse) begin
          coef = MAT[c][r];
        end else begin
          coef = MAT[r][c];
        end
        acc = acc + coef * i_x[c];
      end
      o_y[r] = acc;
    end
  end

endmodule

`default_nettype wire

/* rtl/mcm_lane_group.sv */
`timescale 1ns/1ps
`default_nettype none

module mcm_lane_group (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         i_valid,
  input  wire mcm_pkg::group_sample_t i_samples,
  input  wire mcm_pkg::mode_t         i_mode_s1,
  input  wire mcm_pkg::mode_t         i_mode_s2,
  output mcm_pkg::group_result_t      o_results
);

  mcm_pkg::group_sample_t samples_gated;
  mcm_pkg::group_sample_t samples_q;

  mcm_pkg::quad_result_t dst4_y;
  mcm_pkg::quad_result_t dct4_y;
  mcm_pkg::quad_result_t odd8_y;

  mcm_pkg::quad_result_t dst4_q;
  mcm_pkg::quad_result_t dct4_q;
  mcm_pkg::quad_result_t odd8_q;

  // Idle cycles push zeros through
  assign samples_gated = i_valid ? i_samples : '0;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      samples_q <= '0;
    end else begin
      samples_q <= samples_gated;
    end
  end

  mcm_coef_matrix #(
    .COEF_SET (mcm_pkg::COEF_DST4)
  ) u_dst4 (
    .i_inverse (i_mode_s1.inverse),
    .i_x       (samples_q[3:0]),
    .o_y       (dst4_y)
  );

  mcm_coef_matrix #(
    .COEF_SET (mcm_pkg::COEF_DCT4)
  ) u_dct4 (
    .i_inverse (i_mode_s1.inverse),
    .i_x       (samples_q[3:0]),
    .o_y       (dct4_y)
  );

  // Upper half feeds the odd part of the 8-point transform
  mcm_coef_matrix #(
    .COEF_SET (mcm_pkg::COEF_ODD8)
  ) u_odd8 (
    .i_inverse (i_mode_s1.inverse),
    .i_x       (samples_q[7:4]),
    .o_y       (odd8_y)
  );

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      dst4_q <= '0;
      dct4_q <= '0;
      odd8_q <= '0;
    end else begin
      dst4_q <= dst4_y;
      dct4_q <= dct4_y;
      odd8_q <= odd8_y;
    end
  end

  // Selection uses the mode that travelled with these results
  always_comb begin
    if (i_mode_s2.size == mcm_pkg::TR_SIZE_8) begin
      o_results[3:0] = dct4_q;
      o_results[7:4] = odd8_q;
    end else begin
      if (i_mode_s2.dst_sel) begin
        o_results[3:0] = dst4_q;
      end else begin
        o_results[3:0] = dct4_q;
      end
      o_results[7:4] = '0;
    end
  end

endmodule

`default_nettype wire

/* rtl/mcm_mode_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcm_cfg.svh"

module mcm_mode_ctrl (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    i_valid,
  input  wire mcm_pkg::tr_size_e i_size,
  input  wire                    i_dst_sel,
  input  wire                    i_inverse,
  output mcm_pkg::mode_t         o_mode_s1,
  output mcm_pkg::mode_t         o_mode_s2
);

  mcm_pkg::mode_t mode_d;
  mcm_pkg::mode_t mode_pipe [`MCM_PIPE_DEPTH];

  always_comb begin
    mode_d.valid   = i_valid;
    mode_d.size    = i_size;
    mode_d.dst_sel = i_dst_sel;
    mode_d.inverse = i_inverse;
  end

  // One slot per data stage so each item keeps its own mode
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `MCM_PIPE_DEPTH; i++) begin
        mode_pipe[i] <= '0;
      end
    end else begin
      mode_pipe[0] <= mode_d;
      for (int i = 1; i < `MCM_PIPE_DEPTH; i++) begin
        mode_pipe[i] <= mode_pipe[i-1];
      end
    end
  end

  // Engine direction stage
  assign o_mode_s1 = mode_pipe[0];

  // Result select and output valid stage
  assign o_mode_s2 = mode_pipe[`MCM_PIPE_DEPTH-1];

endmodule

`default_nettype wire

/* rtl/mcm_pkg.sv */
`default_nettype none

`include "mcm_cfg.svh"

package mcm_pkg;

  typedef logic signed [`MCM_SAMPLE_W-1:0] sample_t;
  typedef logic signed [`MCM_COEF_W-1:0] coef_t;
  typedef logic signed [`MCM_RESULT_W-1:0] result_t;

  // Engine operand and result, lane 0 in the low bits
  typedef sample_t [`MCM_GROUP_LANES/2-1:0] quad_sample_t;
  typedef result_t [`MCM_GROUP_LANES/2-1:0] quad_result_t;

  typedef sample_t [`MCM_GROUP_LANES-1:0] group_sample_t;
  typedef result_t [`MCM_GROUP_LANES-1:0] group_result_t;

  typedef sample_t [`MCM_LANES-1:0] sample_vec_t;
  typedef result_t [`MCM_LANES-1:0] result_vec_t;

  typedef enum logic {
    TR_SIZE_4 = 1'b0,
    TR_SIZE_8 = 1'b1
  } tr_size_e;

  // Which constant matrix an engine carries
  typedef enum logic [1:0] {
    COEF_DST4 = 2'd0,
    COEF_DCT4 = 2'd1,
    COEF_ODD8 = 2'd2
  } coef_set_e;

  typedef struct packed {
    logic     valid;
    tr_size_e size;
    logic     dst_sel;
    logic     inverse;
  } mode_t;

endpackage

`default_nettype wire

/* rtl/mcm_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcm_cfg.svh"

module mcm_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_valid,
  input  wire                       i_inverse,
  input  wire mcm_pkg::tr_size_e    i_size,
  input  wire                       i_dst_sel,
  input  wire mcm_pkg::sample_vec_t i_samples,
  output wire                       o_valid,
  output wire mcm_pkg::result_vec_t o_results
);

  localparam int unsigned NUM_GROUPS = `MCM_LANES / `MCM_GROUP_LANES;

  mcm_pkg::mode_t mode_s1;
  mcm_pkg::mode_t mode_s2;

  mcm_mode_ctrl u_mode_ctrl (
    .clk       (clk),
    .rst       (rst),
    .i_valid   (i_valid),
    .i_size    (i_size),
    .i_dst_sel (i_dst_sel),
    .i_inverse (i_inverse),
    .o_mode_s1 (mode_s1),
    .o_mode_s2 (mode_s2)
  );

  // Four identical groups of eight lanes
  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
    mcm_lane_group u_lane_group (
      .clk       (clk),
      .rst       (rst),
      .i_valid   (i_valid),
      .i_samples (i_samples[g*`MCM_GROUP_LANES +: `MCM_GROUP_LANES]),
      .i_mode_s1 (mode_s1),
      .i_mode_s2 (mode_s2),
      .o_results (o_results[g*`MCM_GROUP_LANES +: `MCM_GROUP_LANES])
    );
  end

  assign o_valid = mode_s2.valid;

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
+incdir+dv
rtl/mcm_pkg.sv
rtl/mcm_coef_matrix.sv
rtl/mcm_lane_group.sv
rtl/mcm_mode_ctrl.sv
rtl/mcm_top.sv
dv/mcm_tb.sv
